/* Bender.yml */
package:
  name: softmax_top

sources:
  - common/softmax_pkg.sv
  - common/tile_mem_if.sv
  - arith/exp_unit.sv
  - arith/ln_unit.sv
  - source/tile_counter.sv
  - source/tile_buffer.sv
  - source/tile_prep.sv
  - source/exp_pipe.sv
  - source/softmax_ctrl.sv
  - source/softmax_top.sv
  - target: test
    files:
      - tests/softmax_tb.sv

/* softmax_top.f */
common/softmax_pkg.sv
common/tile_mem_if.sv
arith/exp_unit.sv
arith/ln_unit.sv
source/tile_counter.sv
source/tile_buffer.sv
source/tile_prep.sv
source/exp_pipe.sv
source/softmax_ctrl.sv
source/softmax_top.sv
tests/softmax_tb.sv

/* tests/softmax_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax engine testbench with real-valued
// reference model, framing checks and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module softmax_tb;

    localparam int N_EL        = softmax_pkg::TOTAL_ELEMENTS;
    localparam int TS          = softmax_pkg::TILE_SIZE;
    localparam int EW          = softmax_pkg::ELEM_W;
    localparam int VEC_CYCLES  = 40;                           // One vector with load gaps
    localparam int WATCHDOG_NS = 2 * 5 * VEC_CYCLES * 40 + 400;  // Five vectors, twice over

    logic clk, rst_n, en;
    logic tile_in_valid, tile_in_ready, tile_out_valid, done;
    softmax_pkg::elem_tile_t tile_in, tile_out;

    int seed   = 32'hd571;
    int errors = 0;
    int checks = 0;
    int tests  = 0;
    int vec_in [N_EL];    // Q8.8 inputs
    int vec_out [N_EL];   // Q8.8 probabilities from the DUT
    int base_out [N_EL];

    softmax_top u_softmax_top (
        .clk(clk), .rst_n(rst_n), .en(en), .tile_in(tile_in),
        .tile_in_valid(tile_in_valid), .tile_in_ready(tile_in_ready),
        .tile_out(tile_out), .tile_out_valid(tile_out_valid), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    task automatic check_true(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Fail %0t: %s", $time, msg);
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        tests++;
        $display("Test %-8s %s, %0d errors", name,
                 (errors == err_start) ? "passed" : "FAILED", errors - err_start);
    endtask

    function automatic bit near(input real got, input real want, input real tol);
        return (got - want <= tol) && (want - got <= tol);
    endfunction

    function automatic softmax_pkg::elem_tile_t pack_tile(input int t);
        softmax_pkg::elem_tile_t w;
        for (int i = 0; i < TS; i++)
            w[(TS-1-i)*EW +: EW] = softmax_pkg::elem_t'(vec_in[t*TS+i]);  // Element 0 on top
        return w;
    endfunction

    // Softmax probability of element k, scaled to Q8.8 LSBs
    function automatic real model_q88(input int k);
        real mx;
        real s;
        mx = vec_in[0];
        for (int i = 1; i < N_EL; i++)
            if (vec_in[i] > mx)
                mx = vec_in[i];
        s = 0.0;
        for (int i = 0; i < N_EL; i++)
            s += $exp((vec_in[i] - mx) / 256.0);
        return 256.0 * $exp((vec_in[k] - mx) / 256.0) / s;
    endfunction

    task automatic fill_random();
        for (int i = 0; i < N_EL; i++)
            vec_in[i] = ($random(seed) & 2047) - 1024;  // [-4, 4)
    endtask

    // Start from IDLE, load with random valid gaps, collect output tiles
    task automatic run_vector();
        int                 gap;
        int                 nout;
        bit                 prev_valid;
        bit                 got_done;
        softmax_pkg::elem_t e;
        @(negedge clk);
        en = 1'b1;
        @(negedge clk);
        en = 1'b0;
        for (int t = 0; t < softmax_pkg::NUM_TILES; t++) begin
            gap = $random(seed) & 3;
            repeat (gap) @(negedge clk);
            check_true(tile_in_ready, $sformatf("tile_in_ready low before tile %0d", t));
            tile_in       = pack_tile(t);
            tile_in_valid = 1'b1;
            @(negedge clk);
            tile_in_valid = 1'b0;
        end
        check_true(!tile_in_ready, "tile_in_ready high after the last tile");
        nout       = 0;
        prev_valid = 1'b0;
        got_done   = 1'b0;
        for (int c = 0; c < VEC_CYCLES && !got_done; c++) begin
            @(negedge clk);
            if (done) begin
                got_done = 1'b1;
                check_true(prev_valid && nout == softmax_pkg::NUM_TILES,
                           $sformatf("done after %0d tiles, not right after the last", nout));
            end
            if (tile_out_valid) begin
                check_true(nout == 0 || prev_valid, "gap between output tiles");
                check_true(nout < softmax_pkg::NUM_TILES, "more output tiles than loaded");
                if (nout < softmax_pkg::NUM_TILES)
                    for (int i = 0; i < TS; i++) begin
                        e = tile_out[(TS-1-i)*EW +: EW];
                        vec_out[nout*TS+i] = e;
                    end
                nout++;
            end
            prev_valid = tile_out_valid;
        end
        if (!got_done) begin
            errors++;
            $display("Timeout: no done pulse within %0d cycles after loading", VEC_CYCLES);
        end
        @(negedge clk);
        check_true(!done && !tile_in_ready, "done held or DUT not back in IDLE");
    endtask

    initial begin
        int err_start;
        int out_sum;
        int top;
        rst_n         = 1'b0;
        en            = 1'b0;
        tile_in       = '0;
        tile_in_valid = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        err_start = errors;
        repeat (3) begin  // No load may open without en
            @(negedge clk);
            check_true(!tile_out_valid && !done && !tile_in_ready, "outputs active after reset");
        end
        end_test("reset", err_start);

        err_start = errors;
        for (int i = 0; i < N_EL; i++)
            vec_in[i] = 384;  // All 1.5, each probability 1/16
        run_vector();
        for (int i = 0; i < N_EL; i++)
            check_true(near(vec_out[i], 16, 2),
                       $sformatf("uniform output %0d is %0d, expected 16", i, vec_out[i]));
        end_test("uniform", err_start);

        err_start = errors;
        fill_random();
        run_vector();
        out_sum = 0;
        for (int i = 0; i < N_EL; i++) begin
            check_true(near(vec_out[i], model_q88(i), 3),
                       $sformatf("output %0d is %0d, model %0.2f", i, vec_out[i], model_q88(i)));
            out_sum += vec_out[i];
            base_out[i] = vec_out[i];
        end
        check_true(near(out_sum, 256, 12), $sformatf("outputs sum to %0d, not 256", out_sum));
        end_test("random", err_start);

        err_start = errors;
        top = 0;
        for (int i = 0; i < N_EL; i++) begin
            vec_in[i] += 256;  // Same vector plus 1.0
            if (vec_in[i] > vec_in[top])
                top = i;
        end
        run_vector();
        for (int i = 0; i < N_EL; i++) begin
            check_true(near(vec_out[i], base_out[i], 2),
                       $sformatf("shifted output %0d is %0d, was %0d", i, vec_out[i], base_out[i]));
            check_true(vec_out[top] >= vec_out[i],
                       $sformatf("output %0d exceeds that of the largest input", i));
        end
        end_test("shift", err_start);

        err_start = errors;
        repeat (2) begin  // Back to back runs, each from IDLE
            fill_random();
            run_vector();
        end
        end_test("framing", err_start);

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* source/softmax_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tiled softmax engine top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module softmax_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en,
    input  softmax_pkg::elem_tile_t tile_in,
    input  logic                    tile_in_valid,
    output logic                    tile_in_ready,
    output softmax_pkg::elem_tile_t tile_out,
    output logic                    tile_out_valid,
    output logic                    done
);

    logic                   in_fire;
    logic                   load_phase;
    logic                   sum_phase;
    logic                   log_phase;
    logic                   out_phase;
    logic                   count_en;
    logic                   last_tile;
    logic                   drain_done;
    softmax_pkg::tile_idx_t tile_idx;
    softmax_pkg::fix_t      max_val;
    softmax_pkg::fix_t      ln_sum;
    softmax_pkg::sum_t      exp_sum;

    tile_mem_if mem_bus ();

    assign in_fire       = tile_in_valid & tile_in_ready;
    assign mem_bus.raddr = tile_idx;  // Every pass reads in counter order

    softmax_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .en(en), .in_fire(in_fire),
        .last_tile(last_tile), .drain_done(drain_done),
        .tile_in_ready(tile_in_ready), .load_phase(load_phase),
        .sum_phase(sum_phase), .log_phase(log_phase), .out_phase(out_phase),
        .count_en(count_en), .done(done)
    );

    tile_counter u_counter (
        .clk(clk), .rst_n(rst_n), .count_en(count_en),
        .idx(tile_idx), .last_tile(last_tile)
    );

    tile_buffer u_buffer (.clk(clk), .m(mem_bus.mem));

    tile_prep u_prep (
        .clk(clk), .rst_n(rst_n), .tile_in(tile_in), .in_fire(in_fire),
        .idx(tile_idx), .load_phase(load_phase), .max_val(max_val),
        .wr(mem_bus.writer)
    );

    exp_pipe u_exp_pipe (
        .clk(clk), .rst_n(rst_n), .sum_phase(sum_phase), .out_phase(out_phase),
        .max_val(max_val), .ln_sum(ln_sum), .rd(mem_bus.reader),
        .exp_sum(exp_sum), .drain_done(drain_done),
        .tile_out(tile_out), .tile_out_valid(tile_out_valid)
    );

    ln_unit u_ln (
        .clk(clk), .rst_n(rst_n), .log_phase(log_phase),
        .sum(exp_sum), .ln_sum(ln_sum)
    );

endmodule

/* source/softmax_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pass sequencing FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module softmax_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    input  logic in_fire,
    input  logic last_tile,
    input  logic drain_done,
    output logic tile_in_ready,
    output logic load_phase,
    output logic sum_phase,
    output logic log_phase,
    output logic out_phase,
    output logic count_en,
    output logic done
);

    softmax_pkg::softmax_state_e state, state_next;
    logic drain;  // Last tile issued, pipeline still emptying

    // Reads are issued only until the last tile goes out
    assign load_phase    = (state == softmax_pkg::LOAD);
    assign sum_phase     = (state == softmax_pkg::EXP_SUM) & ~drain;
    assign log_phase     = (state == softmax_pkg::LOG);
    assign out_phase     = (state == softmax_pkg::OUTPUT) & ~drain;
    assign tile_in_ready = load_phase;
    assign count_en      = in_fire | sum_phase | out_phase;
    assign done          = (state == softmax_pkg::DONE);

    always_comb begin
        state_next = state;
        case (state)
            softmax_pkg::IDLE:    if (en) state_next = softmax_pkg::LOAD;
            softmax_pkg::LOAD:    if (in_fire && last_tile) state_next = softmax_pkg::EXP_SUM;
            softmax_pkg::EXP_SUM: if (drain && drain_done) state_next = softmax_pkg::LOG;
            softmax_pkg::LOG:     state_next = softmax_pkg::OUTPUT;
            softmax_pkg::OUTPUT:  if (drain && drain_done) state_next = softmax_pkg::DONE;
            default:              state_next = softmax_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= softmax_pkg::IDLE;
            drain <= 1'b0;
        end else begin
            state <= state_next;
            if (drain && drain_done)
                drain <= 1'b0;
            else if ((sum_phase | out_phase) && last_tile)
                drain <= 1'b1;
        end
    end

endmodule

/* source/exp_pipe.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Max/log-sum shift, exp lanes, sum
// accumulation and Q8.8 output stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module exp_pipe (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sum_phase,
    input  logic                    out_phase,
    input  softmax_pkg::fix_t       max_val,
    input  softmax_pkg::fix_t       ln_sum,
    tile_mem_if.reader              rd,
    output softmax_pkg::sum_t       exp_sum,
    output logic                    drain_done,
    output softmax_pkg::elem_tile_t tile_out,
    output logic                    tile_out_valid
);

    localparam int N  = softmax_pkg::TILE_SIZE;
    localparam int FW = softmax_pkg::FIX_W;

    logic rd_valid, rd_out;  // rdata stage holds a tile, and of which pass
    logic sh_valid, sh_out;  // Same for the shifted stage
    softmax_pkg::fix_tile_t shifted_next, shifted;
    softmax_pkg::fix_t      lane_res [N];
    softmax_pkg::sum_t      tile_sum;

    always_comb begin
        softmax_pkg::fix_t elem;
        softmax_pkg::fix_t diff;
        for (int i = 0; i < N; i++) begin
            elem = rd.rdata[(N-1-i)*FW +: FW];
            diff = elem - max_val - (rd_out ? ln_sum : '0);
            shifted_next[(N-1-i)*FW +: FW] = diff;
        end
    end

    for (genvar g = 0; g < N; g++) begin : g_lane
        exp_unit u_exp (.arg(shifted[(N-1-g)*FW +: FW]), .result(lane_res[g]));
    end

    always_comb begin
        tile_sum = '0;
        for (int i = 0; i < N; i++)
            tile_sum = tile_sum + {{(softmax_pkg::SUM_W-FW){1'b0}}, lane_res[i]};
    end

    // Last sum tile retiring, or last output tile on the port
    assign drain_done = (sh_valid & ~sh_out & ~rd_valid) | (tile_out_valid & ~sh_valid);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid       <= 1'b0;
            rd_out         <= 1'b0;
            sh_valid       <= 1'b0;
            sh_out         <= 1'b0;
            exp_sum        <= '0;
            tile_out_valid <= 1'b0;
        end else begin
            rd_valid       <= sum_phase | out_phase;
            rd_out         <= out_phase;
            sh_valid       <= rd_valid;
            sh_out         <= rd_out;
            tile_out_valid <= sh_valid & sh_out;
            if (sh_valid && !sh_out)
                exp_sum <= exp_sum + tile_sum;
            else if (out_phase)
                exp_sum <= '0;  // Cleared for the next vector once ln is taken
        end
    end

    always_ff @(posedge clk) begin
        shifted <= shifted_next;
        for (int i = 0; i < N; i++)
            tile_out[(N-1-i)*softmax_pkg::ELEM_W +: softmax_pkg::ELEM_W] <=
                lane_res[i][softmax_pkg::FIX_FRAC-softmax_pkg::ELEM_FRAC +: softmax_pkg::ELEM_W];
    end

endmodule

/* source/tile_prep.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Q8.8 to Q16.16 conversion, tile write
// and running maximum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tile_prep (
    input  logic                    clk,
    input  logic                    rst_n,
    input  softmax_pkg::elem_tile_t tile_in,
    input  logic                    in_fire,
    input  softmax_pkg::tile_idx_t  idx,
    input  logic                    load_phase,
    output softmax_pkg::fix_t       max_val,
    tile_mem_if.writer              wr
);

    softmax_pkg::fix_tile_t conv_tile;
    softmax_pkg::fix_t      tile_max;
    logic                   load_d;
    logic                   entering;

    assign entering = load_phase & ~load_d;  // First cycle of LOAD

    always_comb begin
        softmax_pkg::elem_t raw;
        softmax_pkg::fix_t  elem;
        // A tile accepted on the first LOAD cycle must not see the old max
        tile_max = entering ? softmax_pkg::FIX_MIN : max_val;
        for (int i = 0; i < softmax_pkg::TILE_SIZE; i++) begin
            raw  = tile_in[(softmax_pkg::TILE_SIZE-1-i)*softmax_pkg::ELEM_W +: softmax_pkg::ELEM_W];
            elem = {{(softmax_pkg::FIX_W-softmax_pkg::ELEM_W){raw[softmax_pkg::ELEM_W-1]}}, raw}
                   <<< (softmax_pkg::FIX_FRAC - softmax_pkg::ELEM_FRAC);
            conv_tile[(softmax_pkg::TILE_SIZE-1-i)*softmax_pkg::FIX_W +: softmax_pkg::FIX_W] = elem;
            if (elem > tile_max)
                tile_max = elem;
        end
    end

    assign wr.we    = in_fire;
    assign wr.waddr = idx;
    assign wr.wdata = conv_tile;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            max_val <= softmax_pkg::FIX_MIN;
            load_d  <= 1'b0;
        end else begin
            load_d <= load_phase;
            if (in_fire)
                max_val <= tile_max;
            else if (entering)
                max_val <= softmax_pkg::FIX_MIN;
        end
    end

endmodule

/* source/tile_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile memory, one write and one read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tile_buffer (
    input logic        clk,
    tile_mem_if.mem    m
);

    softmax_pkg::fix_tile_t mem [softmax_pkg::NUM_TILES];

    always_ff @(posedge clk) begin
        if (m.we)
            mem[m.waddr] <= m.wdata;
    end

    // Registered read, data follows the address by one cycle
    always_ff @(posedge clk) begin
        m.rdata <= mem[m.raddr];
    end

endmodule

/* source/tile_counter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile index counter with last-tile flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tile_counter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   count_en,
    output softmax_pkg::tile_idx_t idx,
    output logic                   last_tile
);

    localparam softmax_pkg::tile_idx_t LAST_IDX =
        softmax_pkg::tile_idx_t'(softmax_pkg::NUM_TILES - 1);

    // Combinational so the FSM sees it on the same cycle as the index
    assign last_tile = (idx == LAST_IDX);

    // Wraps after each pass so the next one starts from tile 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (count_en) begin
            if (last_tile)
                idx <= '0;
            else
                idx <= idx + 1'b1;
        end
    end

endmodule

/* arith/ln_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Natural log of the exp sum by range
// reduction, registered during LOG
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ln_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              log_phase,
    input  softmax_pkg::sum_t sum,
    output softmax_pkg::fix_t ln_sum
);

    localparam int FW = softmax_pkg::FIX_W;
    localparam int FF = softmax_pkg::FIX_FRAC;
    localparam int SW = softmax_pkg::SUM_W;

    int                     lead;     // Leading one position p
    softmax_pkg::sum_t      norm;
    logic [FF-1:0]          mant;     // m in [0,1)
    logic [2*FF-1:0]        m_sq;
    softmax_pkg::fix_t      m_fix;
    softmax_pkg::fix_t      msq_fix;
    softmax_pkg::fix_t      expo;
    softmax_pkg::fix_t      expo_term;
    logic signed [2*FW-1:0] poly;
    softmax_pkg::fix_t      ln_next;

    always_comb begin
        lead = 0;
        for (int b = 0; b < SW; b++)
            if (sum[b])
                lead = b;
    end

    // sum = 2^(p-16) * (1 + m)
    assign norm    = sum << (SW - 1 - lead);
    assign mant    = norm[SW-2 -: FF];
    assign m_sq    = mant * mant;
    assign m_fix   = {{(FW-FF){1'b0}}, mant};
    assign msq_fix = {{(FW-FF){1'b0}}, m_sq[2*FF-1 -: FF]};

    assign expo      = softmax_pkg::fix_t'(lead - FF);
    assign expo_term = expo * softmax_pkg::LN2_Q;  // Integer times Q16.16
    assign poly      = softmax_pkg::LN_C1 * m_fix + softmax_pkg::LN_C2 * msq_fix;
    assign ln_next   = expo_term + poly[FW+FF-1:FF];

    always_ff @(posedge clk) begin
        if (!rst_n)
            ln_sum <= '0;
        else if (log_phase)
            ln_sum <= ln_next;  // Sum is final by the LOG cycle
    end

endmodule

/* arith/exp_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed-point exp for arguments <= 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module exp_unit (
    input  softmax_pkg::fix_t arg,
    output softmax_pkg::fix_t result
);

    localparam int FW = softmax_pkg::FIX_W;
    localparam int FF = softmax_pkg::FIX_FRAC;

    logic signed [2*FW-1:0]   prod;
    softmax_pkg::fix_t        t;       // arg*log2(e), so e^arg = 2^t
    logic signed [FW-FF-1:0]  k;       // floor(t)
    logic [FF-1:0]            f;       // t - k
    logic [2*FF-1:0]          f_sq;
    softmax_pkg::fix_t        f_fix;
    softmax_pkg::fix_t        fsq_fix;
    logic signed [2*FW-1:0]   lin_term;
    logic signed [2*FW-1:0]   sq_term;
    softmax_pkg::fix_t        pow2_f;
    logic [FW-FF-1:0]         shamt;

    // Base-2 range reduction
    assign prod = arg * softmax_pkg::LOG2E_Q;
    assign t    = prod[FW+FF-1:FF];
    assign k    = t[FW-1:FF];
    assign f    = t[FF-1:0];

    assign f_sq    = f * f;
    assign f_fix   = {{(FW-FF){1'b0}}, f};
    assign fsq_fix = {{(FW-FF){1'b0}}, f_sq[2*FF-1 -: FF]};

    // Quadratic for 2^f, lands in [1,2)
    assign lin_term = softmax_pkg::EXP_C1 * f_fix;
    assign sq_term  = softmax_pkg::EXP_C2 * fsq_fix;
    assign pow2_f   = (softmax_pkg::fix_t'(1) <<< FF)
                    + lin_term[FW+FF-1:FF]
                    + sq_term[FW+FF-1:FF];

    assign shamt = -k;

    always_comb begin
        if (k < -FF)
            result = '0;  // Below one LSB after the shift
        else
            result = pow2_f >> shamt;
    end

endmodule

/* common/tile_mem_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile buffer write and read bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

interface tile_mem_if;

    logic                   we;
    softmax_pkg::tile_idx_t waddr;
    softmax_pkg::fix_tile_t wdata;
    softmax_pkg::tile_idx_t raddr;
    softmax_pkg::fix_tile_t rdata;  // Word at raddr, one cycle later

    modport writer (output we, output waddr, output wdata);

    modport reader (input rdata);

    modport mem (
        input  we,
        input  waddr,
        input  wdata,
        input  raddr,
        output rdata
    );

endinterface

/* common/softmax_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax package with widths, sizes, fixed-point
// constants, vector typedefs and the FSM state enum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package softmax_pkg;

    localparam int ELEM_W         = 16;  // Q8.8 at the ports
    localparam int ELEM_FRAC      = 8;
    localparam int FIX_W          = 32;  // Q16.16 internally
    localparam int FIX_FRAC       = 16;
    localparam int TILE_SIZE      = 4;
    localparam int TOTAL_ELEMENTS = 16;
    localparam int NUM_TILES      = TOTAL_ELEMENTS / TILE_SIZE;
    localparam int TILE_IDX_W     = (NUM_TILES > 1) ? $clog2(NUM_TILES) : 1;
    localparam int SUM_W          = FIX_W + $clog2(TOTAL_ELEMENTS + 1);

    typedef logic signed [ELEM_W-1:0]      elem_t;
    typedef logic signed [FIX_W-1:0]       fix_t;
    typedef logic [SUM_W-1:0]              sum_t;
    typedef logic [TILE_IDX_W-1:0]         tile_idx_t;
    typedef logic [TILE_SIZE*ELEM_W-1:0]   elem_tile_t;  // Element 0 in the top chunk
    typedef logic [TILE_SIZE*FIX_W-1:0]    fix_tile_t;

    localparam fix_t LOG2E_Q = 32'sh0001_7154;  // 1.442695
    localparam fix_t LN2_Q   = 32'sh0000_B172;  // 0.693147

    // 2^f ~ 1 + C1*f + C2*f^2 on [0,1)
    localparam fix_t EXP_C1  = 32'sh0000_A810;  // 0.6565
    localparam fix_t EXP_C2  = 32'sh0000_57F0;  // 0.3435

    // ln(1+m) ~ C1*m + C2*m^2, least squares fit on [0,1)
    localparam fix_t LN_C1   = 32'sh0000_F0D8;  // 0.9408
    localparam fix_t LN_C2   = -32'sd16672;     // -0.2544

    localparam fix_t FIX_MIN = {1'b1, {(FIX_W-1){1'b0}}};

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        EXP_SUM,
        LOG,
        OUTPUT,
        DONE
    } softmax_state_e;

endpackage
